// File: include/mac_config.svh
// Build-time sizing for the shared multiply-add cluster
`ifndef MAC_CONFIG_SVH
`define MAC_CONFIG_SVH

//////////////////////////////
// Cluster dimensions
//////////////////////////////

// Number of cores that submit requests
`define MAC_NUM_CORES 4
// Number of identical multiply-add units
`define MAC_NUM_UNITS 2
// Width of a core index
`define MAC_CORE_IDW 2

// Input pipeline registers inside each unit, at least 1
`define MAC_PRE_REGS 2

`endif

// File: mac_cluster.f
+incdir+include
src/mac_pkg.sv
src/mac_dispatch.sv
src/mac_fma_unit.sv
src/mac_collect.sv
src/mac_cluster_top.sv
test/mac_cluster_assert.sv
test/mac_cluster_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the multiply-add cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f mac_cluster.f --top-module mac_cluster_tb -o mac_cluster_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/mac_cluster_sim 2>&1)
run_status=$?
printf '%s\n' "$out"

if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q '^Simulation finished: PASS$'; then
  exit 0
fi

echo "Pass line not found in simulation output"
exit 1

// File: src/mac_cluster_top.sv
// Shared multiply-add cluster with dispatcher, unit array and result collector
`timescale 1ns/10ps
`default_nettype none

`include "mac_config.svh"

module mac_cluster_top (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  // Request side
  input  logic [`MAC_NUM_CORES-1:0]                  req_i,
  input  mac_pkg::mac_req_t [`MAC_NUM_CORES-1:0]     req_data_i,
  output logic [`MAC_NUM_CORES-1:0]                  gnt_o,
  // Result side
  input  logic [`MAC_NUM_CORES-1:0]                  clr_i,
  output logic [`MAC_NUM_CORES-1:0]                  valid_o,
  output logic [`MAC_NUM_CORES-1:0][31:0]            res_o,
  output mac_pkg::mac_status_t [`MAC_NUM_CORES-1:0]  status_o,
  output mac_pkg::mac_status_t [`MAC_NUM_CORES-1:0]  sticky_o
);

  // Dispatcher to units
  logic [`MAC_NUM_UNITS-1:0]                 issue_valid;
  mac_pkg::mac_issue_t [`MAC_NUM_UNITS-1:0]  issue;

  // Units to collector
  logic [`MAC_NUM_UNITS-1:0]                 res_valid;
  mac_pkg::mac_res_t [`MAC_NUM_UNITS-1:0]    res;

  mac_dispatch i_dispatch (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .req_data_i    (req_data_i),
    .gnt_o         (gnt_o),
    .issue_valid_o (issue_valid),
    .issue_o       (issue)
  );

  // One unit per issue slot, same latency in each
  for (genvar u = 0; u < `MAC_NUM_UNITS; u++) begin : g_units
    mac_fma_unit i_unit (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .en_i    (issue_valid[u]),
      .issue_i (issue[u]),
      .valid_o (res_valid[u]),
      .res_o   (res[u])
    );
  end

  mac_collect i_collect (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .res_valid_i (res_valid),
    .res_i       (res),
    .clr_i       (clr_i),
    .valid_o     (valid_o),
    .res_o       (res_o),
    .status_o    (status_o),
    .sticky_o    (sticky_o)
  );

endmodule

`default_nettype wire

// File: src/mac_collect.sv
// Result collector routing unit results to their cores with sticky status per core
`timescale 1ns/10ps
`default_nettype none

`include "mac_config.svh"

module mac_collect (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  // Unit side
  input  logic [`MAC_NUM_UNITS-1:0]                  res_valid_i,
  input  mac_pkg::mac_res_t [`MAC_NUM_UNITS-1:0]     res_i,
  // Core side
  input  logic [`MAC_NUM_CORES-1:0]                  clr_i,
  output logic [`MAC_NUM_CORES-1:0]                  valid_o,
  output logic [`MAC_NUM_CORES-1:0][31:0]            res_o,
  output mac_pkg::mac_status_t [`MAC_NUM_CORES-1:0]  status_o,
  output mac_pkg::mac_status_t [`MAC_NUM_CORES-1:0]  sticky_o
);

  localparam int NC  = `MAC_NUM_CORES;
  localparam int NU  = `MAC_NUM_UNITS;
  localparam int IDW = `MAC_CORE_IDW;

  // Routed result per core
  logic [NC-1:0]                 hit;
  logic [NC-1:0][31:0]           res_d;
  mac_pkg::mac_status_t [NC-1:0] st_d;

  // Output registers
  logic [NC-1:0]                 valid_q;
  logic [NC-1:0][31:0]           res_q;
  mac_pkg::mac_status_t [NC-1:0] status_q;
  mac_pkg::mac_status_t [NC-1:0] sticky_q;

  // At most one unit names a given core in any cycle
  always_comb begin : p_route
    hit   = '0;
    res_d = '0;
    st_d  = '0;
    for (int c = 0; c < NC; c++) begin
      for (int u = 0; u < NU; u++) begin
        if (res_valid_i[u] && (res_i[u].core_id == IDW'(c))) begin
          hit[c]   = 1'b1;
          res_d[c] = res_i[u].res;
          st_d[c]  = res_i[u].status;
        end
      end
    end
  end

  //////////////////////////////
  // Delivery and sticky flags
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      valid_q  <= '0;
      sticky_q <= '0;
    end else begin
      valid_q <= hit;
      for (int c = 0; c < NC; c++) begin
        // Clear keeps only the flags arriving in the same cycle
        if (clr_i[c]) begin
          sticky_q[c] <= hit[c] ? st_d[c] : '0;
        end else if (hit[c]) begin
          sticky_q[c] <= sticky_q[c] | st_d[c];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_payload
    for (int c = 0; c < NC; c++) begin
      if (hit[c]) begin
        res_q[c]    <= res_d[c];
        status_q[c] <= st_d[c];
      end
    end
  end

  assign valid_o  = valid_q;
  assign res_o    = res_q;
  assign status_o = status_q;
  assign sticky_o = sticky_q;

endmodule

`default_nettype wire

// File: src/mac_dispatch.sv
// Round robin dispatcher granting core requests onto the multiply-add unit slots
`timescale 1ns/10ps
`default_nettype none

`include "mac_config.svh"

module mac_dispatch (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  // Core side
  input  logic [`MAC_NUM_CORES-1:0]                 req_i,
  input  mac_pkg::mac_req_t [`MAC_NUM_CORES-1:0]    req_data_i,
  output logic [`MAC_NUM_CORES-1:0]                 gnt_o,
  // Unit side
  output logic [`MAC_NUM_UNITS-1:0]                 issue_valid_o,
  output mac_pkg::mac_issue_t [`MAC_NUM_UNITS-1:0]  issue_o
);

  localparam int NC  = `MAC_NUM_CORES;
  localparam int NU  = `MAC_NUM_UNITS;
  localparam int IDW = `MAC_CORE_IDW;

  // Rotating priority pointer
  logic [IDW-1:0]                 ptr_q;
  logic [IDW-1:0]                 ptr_d;

  // Grant vector and slot assignment of this cycle
  logic [NC-1:0]                  gnt;
  logic [NU-1:0]                  slot_vld;
  logic [NU-1:0][IDW-1:0]         slot_core;

  // Registered issue towards the units
  logic [NU-1:0]                  issue_vld_q;
  mac_pkg::mac_issue_t [NU-1:0]   issue_q;

  //////////////////////////////
  // Arbitration
  //////////////////////////////

  // Search from the pointer and hand out slots from index 0 upward
  always_comb begin : p_arbitrate
    int idx;
    int n_gnt;
    gnt       = '0;
    slot_vld  = '0;
    slot_core = '0;
    ptr_d     = ptr_q;
    n_gnt     = 0;
    for (int k = 0; k < NC; k++) begin
      idx = (int'(ptr_q) + k) % NC;
      if (req_i[idx] && (n_gnt < NU)) begin
        gnt[idx]         = 1'b1;
        slot_vld[n_gnt]  = 1'b1;
        slot_core[n_gnt] = IDW'(idx);
        // Next search starts after the last granted core
        ptr_d            = IDW'((idx + 1) % NC);
        n_gnt            = n_gnt + 1;
      end
    end
  end

  // Grant is a pulse, the request is taken on this edge
  assign gnt_o = gnt;

  //////////////////////////////
  // Issue registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      ptr_q       <= '0;
      issue_vld_q <= '0;
    end else begin
      ptr_q       <= ptr_d;
      issue_vld_q <= slot_vld;
    end
  end

  // Payload only moves for an occupied slot
  always_ff @(posedge clk_i) begin : p_payload
    for (int s = 0; s < NU; s++) begin
      if (slot_vld[s]) begin
        issue_q[s].core_id <= slot_core[s];
        issue_q[s].req     <= req_data_i[slot_core[s]];
      end
    end
  end

  assign issue_valid_o = issue_vld_q;
  assign issue_o       = issue_q;

endmodule

`default_nettype wire

// File: src/mac_fma_unit.sv
// Pipelined signed Q16.16 multiply-add with sign control, rounding and saturation
`timescale 1ns/10ps
`default_nettype none

`include "mac_config.svh"

module mac_fma_unit (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                en_i,
  input  mac_pkg::mac_issue_t issue_i,
  output logic                valid_o,
  output mac_pkg::mac_res_t   res_o
);

  localparam int PRE = `MAC_PRE_REGS;

  // Signed 32-bit limits at sum width
  localparam logic signed [49:0] SAT_MAX = 50'sd2147483647;
  localparam logic signed [49:0] SAT_MIN = -50'sd2147483648;

  // Input pipeline
  logic [PRE-1:0]                en_q;
  mac_pkg::mac_issue_t [PRE-1:0] iss_q;

  // Datapath on the last input stage
  mac_pkg::mac_issue_t           cur;
  logic [1:0]                    op;
  logic                          rtz;
  logic signed [63:0]            prod;
  logic signed [63:0]            prod_n;
  logic signed [47:0]            prod_fl;
  logic [15:0]                   frac;
  logic                          rnd_up;
  logic signed [48:0]            prod_r;
  logic signed [32:0]            addend;
  logic signed [49:0]            sum;
  logic [31:0]                   res_d;
  mac_pkg::mac_status_t          st_d;

  // Output stage
  logic                          valid_q;
  mac_pkg::mac_res_t             res_q;

  //////////////////////////////
  // Input stages
  //////////////////////////////

  // Enable strobe shifts every cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_pre_en
    if (!rst_ni) begin
      en_q <= '0;
    end else begin
      en_q[0] <= en_i;
      for (int i = 1; i < PRE; i++) begin
        en_q[i] <= en_q[i-1];
      end
    end
  end

  // Operands follow the strobe of the stage before
  always_ff @(posedge clk_i) begin : p_pre_data
    if (en_i) begin
      iss_q[0] <= issue_i;
    end
    for (int i = 1; i < PRE; i++) begin
      if (en_q[i-1]) begin
        iss_q[i] <= iss_q[i-1];
      end
    end
  end

  assign cur = iss_q[PRE-1];
  assign op  = cur.req.op;
  assign rtz = (cur.req.rnd == mac_pkg::MAC_RTZ);

  //////////////////////////////
  // Multiply and round
  //////////////////////////////

  // Full 64-bit product, Q32.32
  assign prod    = $signed(cur.req.opa) * $signed(cur.req.opb);
  assign prod_n  = op[1] ? -prod : prod;
  // Floor of the product in Q16.16 and the dropped fraction
  assign prod_fl = prod_n[63:16];
  assign frac    = prod_n[15:0];

  always_comb begin : p_round
    if (rtz) begin
      // Floor plus one moves a negative value toward zero
      rnd_up = prod_n[63] && (frac != '0);
    end else begin
      // Above half, or exact half on an odd floor
      rnd_up = frac[15] && ((frac[14:0] != '0) || prod_fl[0]);
    end
  end

  assign prod_r = {prod_fl[47], prod_fl} + 49'(rnd_up);

  //////////////////////////////
  // Add and saturate
  //////////////////////////////

  always_comb begin : p_add
    addend = {cur.req.opc[31], cur.req.opc};
    if (op[0]) begin
      addend = -addend;
    end
    sum = {prod_r[48], prod_r} + {{17{addend[32]}}, addend};
  end

  always_comb begin : p_sat
    st_d.ovf = 1'b0;
    if (sum > SAT_MAX) begin
      res_d    = 32'h7FFF_FFFF;
      st_d.ovf = 1'b1;
    end else if (sum < SAT_MIN) begin
      res_d    = 32'h8000_0000;
      st_d.ovf = 1'b1;
    end else begin
      res_d = sum[31:0];
    end
    st_d.inx  = (frac != '0);
    st_d.zero = (res_d == '0);
  end

  //////////////////////////////
  // Output stage
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_post_en
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= en_q[PRE-1];
    end
  end

  always_ff @(posedge clk_i) begin : p_post_data
    if (en_q[PRE-1]) begin
      res_q.core_id <= cur.core_id;
      res_q.res     <= res_d;
      res_q.status  <= st_d;
    end
  end

  assign valid_o = valid_q;
  assign res_o   = res_q;

endmodule

`default_nettype wire

// File: src/mac_pkg.sv
// Shared types for the multiply-add cluster: opcodes, rounding modes and bus structs
`default_nettype none

`include "mac_config.svh"

package mac_pkg;

  //////////////////////////////
  // Encodings
  //////////////////////////////

  // High bit negates the product, low bit negates the addend
  typedef enum logic [1:0] {
    MAC_FMADD  = 2'b00,
    MAC_FMSUB  = 2'b01,
    MAC_FNMSUB = 2'b10,
    MAC_FNMADD = 2'b11
  } mac_op_e;

  // Rounding of the product down to Q16.16
  typedef enum logic {
    MAC_RNE = 1'b0,
    MAC_RTZ = 1'b1
  } mac_rnd_e;

  //////////////////////////////
  // Bus structs
  //////////////////////////////

  // One core request, operands in signed Q16.16
  typedef struct packed {
    mac_op_e     op;
    mac_rnd_e    rnd;
    logic [31:0] opa;
    logic [31:0] opb;
    logic [31:0] opc;
  } mac_req_t;

  // Request tagged with the core that sent it
  typedef struct packed {
    logic [`MAC_CORE_IDW-1:0] core_id;
    mac_req_t                 req;
  } mac_issue_t;

  typedef struct packed {
    logic ovf;   // Result saturated
    logic inx;   // Rounding dropped nonzero bits
    logic zero;  // Result exactly zero
  } mac_status_t;

  // Unit result on its way back to the core
  typedef struct packed {
    logic [`MAC_CORE_IDW-1:0] core_id;
    logic [31:0]              res;
    mac_status_t              status;
  } mac_res_t;

endpackage

`default_nettype wire

// File: test/mac_cluster_assert.sv
// Concurrent checks on grants and result latency of the multiply-add cluster
`timescale 1ns/10ps
`default_nettype none

`include "mac_config.svh"

module mac_cluster_assert (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [`MAC_NUM_CORES-1:0] req_i,
  input  logic [`MAC_NUM_CORES-1:0] gnt_i,
  input  logic [`MAC_NUM_CORES-1:0] valid_i
);

  localparam int NC  = `MAC_NUM_CORES;
  // Grant pulse to result pulse, in cycles
  localparam int LAT = `MAC_PRE_REGS + 3;

  // Grant only to a core that is requesting
  a_gnt_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (gnt_i & ~req_i) == '0)
    else $error("grant given to a core without a request");

  // One slot per unit
  a_gnt_cnt : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $countones(gnt_i) <= `MAC_NUM_UNITS)
    else $error("more grants than units in one cycle");

  // Fixed latency, and no result without a grant
  for (genvar c = 0; c < NC; c++) begin : g_lat
    a_lat : assert property (@(posedge clk_i) disable iff (!rst_ni)
      valid_i[c] == $past(gnt_i[c], LAT))
      else $error("core %0d result not %0d cycles after its grant", c, LAT);
  end

endmodule

`default_nettype wire

// File: test/mac_cluster_tb.sv
// Vector driven testbench for the shared multiply-add cluster
`timescale 1ns/10ps
`default_nettype none

`include "mac_config.svh"

module mac_cluster_tb;

  localparam int NC      = `MAC_NUM_CORES;
  localparam int MAX_VEC = 32;
  localparam int NCOL    = 8;

  logic                          clk_i;
  logic                          rst_ni;
  logic [NC-1:0]                 req;
  mac_pkg::mac_req_t [NC-1:0]    req_data;
  logic [NC-1:0]                 gnt;
  logic [NC-1:0]                 clr;
  logic [NC-1:0]                 valid;
  logic [NC-1:0][31:0]           res;
  mac_pkg::mac_status_t [NC-1:0] status;
  mac_pkg::mac_status_t [NC-1:0] sticky;

  // Vector file image, NCOL words per line
  logic [31:0] vec_mem [MAX_VEC*NCOL];
  int          num_vec;
  // Line offered by each core, -1 when finished
  int          next_vec [NC];
  int          wait_cyc [NC];
  // Expected {status, result} per core in grant order
  logic [34:0] exp_fifo [NC][MAX_VEC];
  int          exp_head [NC];
  int          exp_tail [NC];
  logic [2:0]  sticky_model [NC];
  logic [NC-1:0] gnt_seen;
  bit          started;
  int          seed;
  int          cycles = 0;
  int          limit = 0;
  int          errors;
  int          checks;

  mac_cluster_top dut0 (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req),
    .req_data_i (req_data),
    .gnt_o      (gnt),
    .clr_i      (clr),
    .valid_o    (valid),
    .res_o      (res),
    .status_o   (status),
    .sticky_o   (sticky)
  );

  bind mac_cluster_top mac_cluster_assert i_assert (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req_i),
    .gnt_i   (gnt_o),
    .valid_i (valid_o)
  );

  initial begin : p_clock
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  // First line at or after from that belongs to core c
  function automatic int find_line(int c, int from);
    int found;
    found = -1;
    for (int i = num_vec - 1; i >= from; i--) begin
      if (vec_mem[i*NCOL] == 32'(c)) found = i;
    end
    return found;
  endfunction

  function automatic bit all_done();
    bit d;
    d = (gnt_seen == '0);
    for (int c = 0; c < NC; c++) begin
      if ((next_vec[c] >= 0) || (exp_head[c] != exp_tail[c])) d = 1'b0;
    end
    return d;
  endfunction

  // Outputs are registered, stable at the falling edge
  task automatic check_results();
    logic [34:0] entry;
    logic [2:0]  exp_st;
    for (int c = 0; c < NC; c++) begin
      exp_st = 3'b000;
      if (valid[c]) begin
        if (exp_head[c] == exp_tail[c]) begin
          $display("ERROR core %0d received a result with no request pending", c);
          errors++;
        end else begin
          entry = exp_fifo[c][exp_head[c]];
          exp_head[c]++;
          exp_st = entry[34:32];
          check_value($sformatf("core%0d res", c), entry[31:0], res[c]);
          check_value($sformatf("core%0d status", c), 32'(exp_st), 32'(status[c]));
        end
      end
      // Clear seen at the last edge keeps only this delivery
      if (clr[c]) begin
        sticky_model[c] = valid[c] ? exp_st : 3'b000;
      end else if (valid[c]) begin
        sticky_model[c] = sticky_model[c] | exp_st;
      end
      check_value($sformatf("core%0d sticky", c), 32'(sticky_model[c]), 32'(sticky[c]));
    end
  endtask

  // Take granted lines, then hold, idle or raise the next one
  task automatic drive_inputs();
    logic [31:0] rnd;
    int          b;
    for (int c = 0; c < NC; c++) begin
      if (gnt_seen[c]) begin
        b = next_vec[c] * NCOL;
        exp_fifo[c][exp_tail[c]] = {vec_mem[b+7][2:0], vec_mem[b+6]};
        exp_tail[c]++;
        next_vec[c] = find_line(c, next_vec[c] + 1);
      end
      if (next_vec[c] < 0) begin
        req[c] = 1'b0;
      end else if (req[c] && !gnt_seen[c]) begin
        wait_cyc[c]++;
        if (wait_cyc[c] >= NC) begin
          $display("ERROR core %0d waited %0d cycles for a grant", c, wait_cyc[c]);
          errors++;
        end
      end else begin
        rnd = $random(seed);
        if (started && (rnd[1:0] == 2'b00)) begin
          req[c] = 1'b0;
        end else begin
          b = next_vec[c] * NCOL;
          req[c]          = 1'b1;
          wait_cyc[c]     = 0;
          req_data[c].op  = mac_pkg::mac_op_e'(vec_mem[b+1][1:0]);
          req_data[c].rnd = mac_pkg::mac_rnd_e'(vec_mem[b+2][0]);
          req_data[c].opa = vec_mem[b+3];
          req_data[c].opb = vec_mem[b+4];
          req_data[c].opc = vec_mem[b+5];
        end
      end
      clr[c] = started && ((cycles % 9) == (2 * c + 1));
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin : p_main
    seed     = 49;
    errors   = 0;
    checks   = 0;
    started  = 1'b0;
    rst_ni   = 1'b0;
    req      = '0;
    req_data = '0;
    clr      = '0;
    gnt_seen = '0;
    for (int i = 0; i < MAX_VEC * NCOL; i++) begin
      vec_mem[i] = ~32'(i);
    end
    $readmemh("test/mac_cluster_vectors.txt", vec_mem);
    num_vec = 0;
    while ((num_vec < MAX_VEC) && (vec_mem[num_vec*NCOL] < 32'(NC))) num_vec++;
    if (num_vec == 0) begin
      $display("ERROR no vectors found in the vector file");
      errors++;
    end
    limit = num_vec * NC + 100;
    for (int c = 0; c < NC; c++) begin
      next_vec[c]     = find_line(c, 0);
      exp_head[c]     = 0;
      exp_tail[c]     = 0;
      wait_cyc[c]     = 0;
      sticky_model[c] = 3'b000;
    end
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    // Quiet outputs after reset
    repeat (2) begin
      @(negedge clk_i);
      check_value("idle gnt", '0, 32'(gnt));
      check_value("idle valid", '0, 32'(valid));
      check_value("idle sticky", '0, 32'(sticky));
    end
    while (!all_done()) begin
      @(negedge clk_i);
      check_results();
      drive_inputs();
      started = 1'b1;
      #1;
      gnt_seen = gnt;
      check_value("gnt without req", '0, 32'(gnt & ~req));
    end
    // Catch any stray result
    repeat (`MAC_PRE_REGS + 4) begin
      @(negedge clk_i);
      check_results();
    end
    for (int c = 0; c < NC; c++) begin
      if (exp_head[c] != exp_tail[c]) begin
        $display("ERROR core %0d is missing %0d results", c, exp_tail[c] - exp_head[c]);
        errors++;
      end
    end
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Run limit scales with the vector count
  initial begin : p_timeout
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("ERROR timeout after %0d cycles, results still outstanding", cycles);
    $display("checks %0d errors %0d", checks, errors + 1);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/mac_cluster_vectors.txt
// core op rnd A B C expected_res expected_status
// hex, Q16.16 operands, status bits are {ovf, inx, zero}
0 0 0 00020000 00030000 00010000 00070000 0
1 0 0 00000001 00008000 00000000 00000000 3
2 0 0 FFFFFFFD 00008000 00000000 FFFFFFFE 2
3 0 0 7FFF0000 00020000 00000000 7FFFFFFF 4
0 1 0 00020000 00030000 00010000 00050000 0
1 0 0 00000003 00008000 00000000 00000002 2
2 0 0 00000001 0000C000 00000000 00000001 2
3 3 0 7FFF0000 00020000 00010000 80000000 4
0 2 0 00020000 00030000 00010000 FFFB0000 0
1 0 1 00000003 00008000 00000000 00000001 2
2 0 1 00000001 0000C000 00000000 00000000 3
3 0 0 7FFF0000 00010000 0000FFFF 7FFFFFFF 0
0 3 0 00020000 00030000 00010000 FFF90000 0
1 0 1 FFFFFFFD 00008000 00000000 FFFFFFFF 2
2 1 0 00020000 00030000 00060000 00000000 1
3 1 1 00010000 00010000 FFFF0000 00020000 0
